/* verilog/srcIsaPkg.sv */
package srcIsaPkg;

    localparam int wordWidth   = 32;          // machine word.
    localparam int numRegs     = 16;          // general purpose registers.
    localparam int regIdxWidth = 4;           // bits per register index.

    // instruction field positions
    localparam int opMsb = 31;                // opcode field.
    localparam int opLsb = 27;
    localparam int raMsb = 26;                // destination / source ra.
    localparam int raLsb = 23;
    localparam int rbMsb = 22;                // base or first operand.
    localparam int rbLsb = 19;
    localparam int rcMsb = 18;                // second operand.
    localparam int rcLsb = 15;
    localparam int cMsb  = 18;                // immediate constant.
    localparam int cLsb  = 0;

    localparam int opWidth = opMsb - opLsb + 1;
    localparam int cWidth  = cMsb - cLsb + 1; // 19 bits, sign-extended.

    typedef logic [wordWidth-1:0]   srcWordT;
    typedef logic [regIdxWidth-1:0] regIdxT;

    // opcodes follow the usual mini src numbering
    typedef enum logic [opWidth-1:0] {
        opLd   = 5'd0,                        // ra <- mem[rb + c].
        opLdi  = 5'd1,                        // ra <- rb + c.
        opSt   = 5'd2,                        // mem[rb + c] <- ra.
        opAdd  = 5'd3,                        // ra <- rb + rc.
        opSub  = 5'd4,                        // ra <- rb - rc.
        opOut  = 5'd23,                       // out port <- ra.
        opNop  = 5'd26,
        opHalt = 5'd27                        // stop fetching.
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd,                               // a + b.
        aluSub,                               // a - b.
        aluInc,                               // b + 1.
        aluPassB,                             // b.
        aluNop                                // b, nothing meant.
    } aluOpT;

endpackage

/* verilog/srcCtrlPkg.sv */
package srcCtrlPkg;

    import srcIsaPkg::*;

    // sequencer steps, fetch then execute
    typedef enum logic [3:0] {
        stIdle,                               // just out of reset.
        stT0,                                 // pc to mar, pc + 1 to z.
        stT1,                                 // z to pc, fetch request.
        stFetchWait,                          // wait for ack.
        stFetchRel,                           // wait for ack to drop.
        stT2,                                 // mdr to ir.
        stT3,                                 // first decode step.
        stT4,
        stT5,
        stT6,
        stMemWait,                            // data access, wait for ack.
        stMemRel,                             // data access, wait for release.
        stT7,                                 // ld write back.
        stHalted
    } stepT;

    // one control word per step
    typedef struct packed {
        logic  pcOut;                         // bus sources.
        logic  zLowOut;
        logic  mdrOut;
        logic  cOut;
        logic  rOut;
        logic  baOut;                         // r0 reads as zero.
        logic  incPc;                         // alu forced to increment.
        logic  pcIn;                          // register loads.
        logic  irIn;
        logic  yIn;
        logic  zIn;
        logic  mdrIn;
        logic  marIn;
        logic  rIn;
        logic  outIn;
        logic  gra;                           // register select.
        logic  grb;
        logic  grc;
        logic  memLoad;                       // mdr from memory, not bus.
        aluOpT aluOp;
    } ctrlWordT;

    // memory request port
    typedef struct packed {
        logic    req;                         // four-phase request.
        logic    write;                       // 1 = store.
        srcWordT addr;
        srcWordT wdata;
    } memReqT;

endpackage

/* verilog/aluUnit.sv */
`timescale 1ns/100ps

module aluUnit
    import srcIsaPkg::*;
(
    input  aluOpT   aluOp,
    input  srcWordT a,
    input  srcWordT b,
    output srcWordT result
);

    always_comb begin
        case (aluOp)
            aluAdd:   result = a + b;                        // wraps mod 2^32.
            aluSub:   result = a - b;
            aluInc:   result = b + srcWordT'(1);             // pc step.
            aluPassB: result = b;
            default:  result = b;                            // nop passes b.
        endcase
    end

endmodule

/* verilog/registerFile.sv */
`timescale 1ns/100ps

module registerFile
    import srcIsaPkg::*, srcCtrlPkg::*;
(
    input  logic     clock,
    input  logic     rstN,
    input  ctrlWordT ctrl,
    input  srcWordT  ir,
    input  srcWordT  busIn,
    output srcWordT  regOut
);

    srcWordT regs [numRegs];
    regIdxT  sel;

    // gra/grb/grc pick the field from ir
    always_comb begin
        sel = '0;
        if (ctrl.gra) begin
            sel = ir[raMsb:raLsb];
        end else if (ctrl.grb) begin
            sel = ir[rbMsb:rbLsb];
        end else if (ctrl.grc) begin
            sel = ir[rcMsb:rcLsb];
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;                               // clean start.
            end
        end else if (ctrl.rIn) begin
            regs[sel] <= busIn;                              // bus to selected reg.
        end
    end

    // base register r0 gives absolute address
    assign regOut = (ctrl.baOut && sel == '0) ? '0 : regs[sel];

endmodule

/* verilog/datapathBus.sv */
`timescale 1ns/100ps

module datapathBus
    import srcIsaPkg::*, srcCtrlPkg::*;
(
    input  logic     clock,
    input  logic     rstN,
    input  ctrlWordT ctrl,
    input  srcWordT  regOut,
    input  srcWordT  aluResult,
    input  srcWordT  memRdata,
    input  logic     memAck,
    output srcWordT  ir,
    output srcWordT  yOut,
    output srcWordT  bus,
    output srcWordT  marOut,
    output srcWordT  mdrOut,
    output srcWordT  outData,
    output logic     outStrobe
);

    srcWordT pc;
    srcWordT irReg;
    srcWordT y;
    srcWordT z;
    srcWordT mar;
    srcWordT mdr;
    srcWordT outReg;
    srcWordT cExt;
    logic    strobeReg;

    assign cExt = {{(wordWidth - cWidth){irReg[cMsb]}}, irReg[cMsb:cLsb]};  // sign-extend c.

    // one source per step
    always_comb begin
        if (ctrl.pcOut) begin
            bus = pc;
        end else if (ctrl.zLowOut) begin
            bus = z;
        end else if (ctrl.mdrOut) begin
            bus = mdr;
        end else if (ctrl.cOut) begin
            bus = cExt;
        end else if (ctrl.rOut) begin
            bus = regOut;
        end else begin
            bus = '0;                                        // idle bus.
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc  <= '0;
            irReg <= '0;
            y   <= '0;
            z   <= '0;
            mar <= '0;
            mdr <= '0;
        end else begin
            if (ctrl.pcIn)  pc    <= bus;
            if (ctrl.irIn)  irReg <= bus;
            if (ctrl.yIn)   y     <= bus;
            if (ctrl.zIn)   z     <= aluResult;              // alu result held in z.
            if (ctrl.marIn) mar   <= bus;
            if (ctrl.memLoad) begin
                if (memAck) mdr <= memRdata;                 // read data with ack.
            end else if (ctrl.mdrIn) begin
                mdr <= bus;
            end
        end
    end

    // output port, strobe one cycle after load
    always_ff @(posedge clock) begin
        if (ctrl.outIn) outReg <= bus;
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            strobeReg <= 1'b0;
        end else begin
            strobeReg <= ctrl.outIn;
        end
    end

    assign ir        = irReg;
    assign yOut      = y;
    assign marOut    = mar;
    assign mdrOut    = mdr;
    assign outData   = outReg;
    assign outStrobe = strobeReg;

endmodule

/* verilog/controlSequencer.sv */
`timescale 1ns/100ps

module controlSequencer
    import srcIsaPkg::*, srcCtrlPkg::*;
(
    input  logic     clock,
    input  logic     rstN,
    input  opcodeT   opcode,
    input  logic     memAck,
    output ctrlWordT ctrl,
    output logic     memReq,
    output logic     memWrite,
    output logic     halted
);

    stepT     step;
    stepT     stepNext;
    ctrlWordT cw;
    aluOpT    aluSel;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            step <= stIdle;
        end else begin
            step <= stepNext;
        end
    end

    always_comb begin
        stepNext = step;                                      // hold by default.
        case (step)
            stIdle:      stepNext = stT0;
            stT0:        stepNext = stT1;
            stT1:        stepNext = stFetchWait;
            stFetchWait: if (memAck) stepNext = stFetchRel;   // data taken.
            stFetchRel:  if (!memAck) stepNext = stT2;        // handshake done.
            stT2:        stepNext = stT3;
            stT3: begin
                case (opcode)                                 // ir valid from here.
                    opLd, opLdi, opSt, opAdd, opSub: stepNext = stT4;
                    opHalt:  stepNext = stHalted;
                    default: stepNext = stT0;                 // out and nop end here.
                endcase
            end
            stT4:        stepNext = stT5;
            stT5:        stepNext = (opcode == opLd || opcode == opSt) ? stT6 : stT0;
            stT6:        stepNext = stMemWait;
            stMemWait:   if (memAck) stepNext = stMemRel;
            stMemRel:    if (!memAck) stepNext = (opcode == opLd) ? stT7 : stT0;
            stT7:        stepNext = stT0;
            stHalted:    stepNext = stHalted;                 // only reset leaves.
            default:     stepNext = stIdle;
        endcase
    end

    // control word per step, all zero unless set
    always_comb begin
        cw     = '0;
        aluSel = aluNop;
        case (step)
            stT0: begin
                cw.pcOut = 1'b1;                              // pc onto bus.
                cw.marIn = 1'b1;
                cw.incPc = 1'b1;
                cw.zIn   = 1'b1;                              // z <- pc + 1.
            end
            stT1, stFetchWait: begin
                cw.memLoad = 1'b1;                            // mdr follows memory.
                if (step == stT1) begin
                    cw.zLowOut = 1'b1;
                    cw.pcIn    = 1'b1;                        // pc <- z.
                end
            end
            stT2: begin
                cw.mdrOut = 1'b1;
                cw.irIn   = 1'b1;                             // instruction latched.
            end
            stT3: begin
                cw.rOut = 1'b1;
                if (opcode == opOut) begin
                    cw.gra   = 1'b1;
                    cw.outIn = 1'b1;                          // ra to out port.
                end else begin
                    cw.grb   = 1'b1;
                    cw.yIn   = 1'b1;                          // y <- rb.
                    cw.baOut = (opcode == opLd || opcode == opLdi || opcode == opSt);
                    cw.rOut  = (opcode != opHalt && opcode != opNop);
                    cw.yIn   = cw.rOut;
                    cw.grb   = cw.rOut;
                end
            end
            stT4: begin
                cw.zIn = 1'b1;
                if (opcode == opAdd || opcode == opSub) begin
                    cw.grc = 1'b1;
                    cw.rOut = 1'b1;                           // b operand is rc.
                    aluSel = (opcode == opSub) ? aluSub : aluAdd;
                end else begin
                    cw.cOut = 1'b1;                           // b operand is c.
                    aluSel  = aluAdd;                         // effective address.
                end
            end
            stT5: begin
                cw.zLowOut = 1'b1;
                if (opcode == opLd || opcode == opSt) begin
                    cw.marIn = 1'b1;                          // address to mar.
                end else begin
                    cw.gra = 1'b1;
                    cw.rIn = 1'b1;                            // result to ra.
                end
            end
            stT6: begin
                if (opcode == opSt) begin
                    cw.gra   = 1'b1;
                    cw.rOut  = 1'b1;
                    cw.mdrIn = 1'b1;                          // store data to mdr.
                end else begin
                    cw.memLoad = 1'b1;                        // read request opens.
                end
            end
            stMemWait: cw.memLoad = (opcode == opLd);
            stT7: begin
                cw.mdrOut = 1'b1;
                cw.gra    = 1'b1;
                cw.rIn    = 1'b1;                             // ra <- loaded word.
            end
            default: ;
        endcase
        cw.aluOp = cw.incPc ? aluInc : aluSel;
    end

    assign ctrl     = cw;
    assign memReq   = (step == stT1) || (step == stFetchWait) || (step == stMemWait)
                    || (step == stT6 && opcode == opLd);      // held until ack.
    assign memWrite = (step == stMemWait) && (opcode == opSt);
    assign halted   = (step == stHalted);

endmodule

/* verilog/miniSrcTop.sv */
`timescale 1ns/100ps

module miniSrcTop
    import srcIsaPkg::*, srcCtrlPkg::*;
(
    input  logic    clock,
    input  logic    rstN,
    output memReqT  memReq,
    input  logic    memAck,
    input  srcWordT memRdata,
    output srcWordT outData,
    output logic    outStrobe,
    output logic    halted
);

    ctrlWordT ctrl;
    opcodeT   opcode;
    srcWordT  ir, yOut, bus, marOut, mdrOut, regOut, aluResult;
    logic     seqReq, seqWrite;

    assign opcode = opcodeT'(ir[opMsb:opLsb]);               // opcode field of ir.
    assign memReq = '{req: seqReq, write: seqWrite, addr: marOut, wdata: mdrOut};

    controlSequencer u_controlSequencer (
        .clock(clock), .rstN(rstN), .opcode(opcode), .memAck(memAck),
        .ctrl(ctrl), .memReq(seqReq), .memWrite(seqWrite), .halted(halted));

    datapathBus u_datapathBus (
        .clock(clock), .rstN(rstN), .ctrl(ctrl), .regOut(regOut),
        .aluResult(aluResult), .memRdata(memRdata), .memAck(memAck),
        .ir(ir), .yOut(yOut), .bus(bus), .marOut(marOut), .mdrOut(mdrOut),
        .outData(outData), .outStrobe(outStrobe));

    registerFile u_registerFile (
        .clock(clock), .rstN(rstN), .ctrl(ctrl), .ir(ir), .busIn(bus), .regOut(regOut));

    aluUnit u_aluUnit (
        .aluOp(ctrl.aluOp), .a(yOut), .b(bus), .result(aluResult));  // y op bus.

endmodule

/* bench/miniSrcTb.sv */
`timescale 1ns/100ps

module miniSrcTb
    import srcIsaPkg::*, srcCtrlPkg::*;
();

    localparam int resetTimeout   = 20;                // cycles.
    localparam int reqTimeout     = 100;
    localparam int releaseTimeout = 100;
    localparam int haltTimeout    = 4000;
    localparam int quietCycles    = 30;                // window after halt.

    logic    clock;
    logic    rstN     = 1'b0;
    logic    memAck   = 1'b0;
    srcWordT memRdata = '0;
    memReqT  memReq;
    srcWordT outData;
    logic    outStrobe;
    logic    halted;

    srcWordT     memory [srcWordT];                    // sparse memory image.
    srcWordT     storeAddr [$];
    srcWordT     storeData [$];
    srcWordT     outExp [$];
    int          storeIdx  = 0;
    int          outIdx    = 0;
    int          errors    = 0;
    int          testCount = 0;
    logic        firstDone = 1'b0;
    logic [15:0] lfsr      = 16'd87;                   // seed.

    miniSrcTop u_miniSrcTop (
        .clock(clock), .rstN(rstN), .memReq(memReq), .memAck(memAck),
        .memRdata(memRdata), .outData(outData), .outStrobe(outStrobe), .halted(halted));

    initial begin : clockGen
        clock = 1'b0;
        forever #20 clock = ~clock;                    // 40 ns period.
    end

    task automatic endRun();
        $display("tests %0d, failures %0d", testCount, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic timeoutFail(input string what);
        $display("timeout, %s", what);
        errors++;
        endRun();
    endtask

    task automatic checkWord(input string name, input srcWordT expected, input srcWordT actual);
        testCount++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end else begin
            $display("ok  %s", name);
        end
    endtask

    task automatic checkStore(input string name, input memReqT expected, input memReqT actual);
        testCount++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end else begin
            $display("ok  %s", name);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        testCount++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %b actual %b", name, expected, actual);
        end else begin
            $display("ok  %s", name);
        end
    endtask

    // galois step, taps for a maximal 16-bit sequence
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic drawBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | lfsr[0];            // one bit per step.
            lfsr  = lfsrNext(lfsr);
        end
    endtask

    task automatic idleCycles();
        int n;
        drawBits(2, n);                                // 0 to 3 cycles.
        repeat (n) @(negedge clock);
    endtask

    function automatic srcWordT readMemory(input srcWordT addr);
        if (memory.exists(addr)) return memory[addr];
        return addr ^ 32'hDEAD_BEEF;                   // unmapped fill.
    endfunction

    task automatic loadTestdata();
        int              fd;
        int              code;
        logic [7:0]      kind;
        logic [8*128-1:0] rest;
        srcWordT         addr;
        srcWordT         word;
        fd = $fopen("bench/miniSrcTestdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file");
            errors++;
            endRun();
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                case (kind)
                    "M": begin
                        code = $fscanf(fd, "%h %h", addr, word);
                        memory[addr] = word;           // image word.
                    end
                    "W": begin
                        code = $fscanf(fd, "%h %h", addr, word);
                        storeAddr.push_back(addr);
                        storeData.push_back(word);
                    end
                    "O": begin
                        code = $fscanf(fd, "%h", word);
                        outExp.push_back(word);
                    end
                    "#": code = $fgets(rest, fd);      // comment line.
                    default: begin
                        errors++;
                        $display("unknown line kind in the test data file");
                    end
                endcase
            end
            $fclose(fd);
        end
    endtask

    // one four-phase transfer, delays before both ack edges
    task automatic serveRequest();
        memReqT seen;
        int     cycles;
        seen = memReq;
        if (!firstDone) begin
            checkStore("first fetch",
                memReqT'{req: 1'b1, write: 1'b0, addr: '0, wdata: '0}, seen);
            firstDone = 1'b1;
        end
        if (seen.write) begin
            if (storeIdx < storeAddr.size()) begin
                checkStore($sformatf("store %0d", storeIdx), memReqT'{req: 1'b1, write: 1'b1,
                    addr: storeAddr[storeIdx], wdata: storeData[storeIdx]}, seen);
            end else begin
                errors++;
                $display("store request beyond the expected list");
            end
            storeIdx++;
            memory[seen.addr] = seen.wdata;            // later loads see it.
        end
        idleCycles();
        memRdata = seen.write ? '0 : readMemory(seen.addr);
        memAck   = 1'b1;
        cycles   = 0;
        while (memReq.req && cycles < releaseTimeout) begin
            @(negedge clock);
            cycles++;
        end
        if (memReq.req) begin
            timeoutFail("request never dropped after acknowledge");
        end else begin
            drawBits(2, cycles);                       // 0 to 3 cycles before release.
            repeat (cycles) begin
                @(negedge clock);
                if (memReq.req) begin
                    errors++;
                    $display("request rose while acknowledge was still high");
                end
            end
            memAck = 1'b0;                             // handshake closed.
        end
    endtask

    initial begin : memoryResponder
        int cycles;
        cycles = 0;
        while (rstN !== 1'b1 && cycles < resetTimeout) begin
            @(negedge clock);
            cycles++;
        end
        while (halted !== 1'b1) begin
            cycles = 0;
            while (!memReq.req && halted !== 1'b1 && cycles < reqTimeout) begin
                @(negedge clock);
                cycles++;
            end
            if (!memReq.req && halted !== 1'b1) begin
                timeoutFail("no memory request arrived");
            end else if (memReq.req) begin
                serveRequest();
            end
        end
    end

    always @(negedge clock) begin : portMonitor
        if (outStrobe) begin
            if (outIdx < outExp.size()) begin
                checkWord($sformatf("out %0d", outIdx), outExp[outIdx], outData);
            end else begin
                errors++;
                $display("out strobe beyond the expected list");
            end
            outIdx++;
        end
    end

    initial begin : mainSequence
        int   cycles;
        logic reqAfterHalt;
        loadTestdata();
        repeat (4) @(negedge clock);                   // reset held 4 cycles.
        checkStore("reset request", '0, memReq);
        checkFlag("reset out strobe", 1'b0, outStrobe);
        checkFlag("reset halted", 1'b0, halted);
        rstN   = 1'b1;
        cycles = 0;
        while (halted !== 1'b1 && cycles < haltTimeout) begin
            @(negedge clock);
            cycles++;
        end
        if (halted !== 1'b1) begin
            timeoutFail("halted never went high");
        end else begin
            reqAfterHalt = 1'b0;
            repeat (quietCycles) begin
                @(negedge clock);
                reqAfterHalt = reqAfterHalt | memReq.req;
            end
            checkFlag("no request after halt", 1'b0, reqAfterHalt);
            checkWord("out strobe count", srcWordT'(outExp.size()), srcWordT'(outIdx));
            checkWord("store count", srcWordT'(storeAddr.size()), srcWordT'(storeIdx));
            endRun();
        end
    end

endmodule

/* bench/miniSrcTestdata.txt */
# M address word is the memory image, W address word is an expected store in order
# O word is an expected output port value in order
M 00000000 08800040
M 00000001 01080000
M 00000002 B9000000
M 00000003 018FFFFF
M 00000004 B9800000
M 00000005 02000041
M 00000006 1A920000
M 00000007 BA800000
M 00000008 23210000
M 00000009 BB000000
M 0000000A 12800050
M 0000000B 13080002
M 0000000C 03800050
M 0000000D BB800000
M 0000000E D8000000
M 0000003F CAFEF00D
M 00000040 12345678
M 00000041 000000FF
W 00000050 12345777
W 00000042 EDCBAA87
O 12345678
O CAFEF00D
O 12345777
O EDCBAA87
O 12345777

/* tb.f */
verilog/srcIsaPkg.sv
verilog/srcCtrlPkg.sv
verilog/aluUnit.sv
verilog/registerFile.sv
verilog/datapathBus.sv
verilog/controlSequencer.sv
verilog/miniSrcTop.sv
bench/miniSrcTb.sv

/* Bender.yml */
package:
  name: mini_src

sources:
  - verilog/srcIsaPkg.sv
  - verilog/srcCtrlPkg.sv
  - verilog/aluUnit.sv
  - verilog/registerFile.sv
  - verilog/datapathBus.sv
  - verilog/controlSequencer.sv
  - verilog/miniSrcTop.sv
  - target: simulation
    files:
      - bench/miniSrcTb.sv
